/* source/mem_stage_pkg.sv */
package mem_stage_pkg;

	// memory operation codes from the execute stage
	localparam int MEM_OP_W = 4;

	localparam logic [MEM_OP_W-1:0] MEN_X   = 4'd0;
	localparam logic [MEM_OP_W-1:0] MEN_LB  = 4'd1;
	localparam logic [MEM_OP_W-1:0] MEN_LBU = 4'd2;
	localparam logic [MEM_OP_W-1:0] MEN_LH  = 4'd3;
	localparam logic [MEM_OP_W-1:0] MEN_LHU = 4'd4;
	localparam logic [MEM_OP_W-1:0] MEN_LW  = 4'd5;
	localparam logic [MEM_OP_W-1:0] MEN_SB  = 4'd6;
	localparam logic [MEM_OP_W-1:0] MEN_SH  = 4'd7;
	localparam logic [MEM_OP_W-1:0] MEN_SW  = 4'd8;

	// commands between the stage and the data memory controller
	localparam int MEM_CMD_W = 2;

	localparam logic [MEM_CMD_W-1:0] MEMORY_CMD_NOP   = 2'd0;
	localparam logic [MEM_CMD_W-1:0] MEMORY_CMD_READ  = 2'd1;
	localparam logic [MEM_CMD_W-1:0] MEMORY_CMD_WRITE = 2'd2;

	localparam int WB_SEL_W = 4;

	localparam int DMEM_WORDS = 256;
	localparam int DMEM_AW    = 8;

	// memory stage state machine
	localparam int STATE_W = 2;

	localparam logic [STATE_W-1:0] ST_WAIT            = 2'd0;
	localparam logic [STATE_W-1:0] ST_WAIT_READY      = 2'd1;
	localparam logic [STATE_W-1:0] ST_WAIT_READ_VALID = 2'd2;
	localparam logic [STATE_W-1:0] ST_END             = 2'd3;

	// byte 0 and half 0 sit at the low end of the word (little endian lanes)
	typedef union packed {
		logic [31:0]      word;
		logic [3:0][7:0]  bytes;
		logic [1:0][15:0] halves;
	} mem_word_t;

endpackage

/* source/byte_lane_ram.sv */
`timescale 1ns/1ps

module byte_lane_ram (
	input  logic                               clk,
	input  logic                               en,
	input  logic                               we,
	input  logic [mem_stage_pkg::DMEM_AW-1:0]  addr,
	input  logic [7:0]                         wdata,
	output logic [7:0]                         rdata
);
	import mem_stage_pkg::*;

	logic [7:0] mem [DMEM_WORDS];

	// rdata holds the last read until the next enabled read
	always_ff @(posedge clk) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr];
		end
	end

endmodule

/* source/read_return.sv */
`timescale 1ns/1ps

module read_return (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [3:0][7:0]           lane_rdata,
	input  logic                      rd_pending,
	output mem_stage_pkg::mem_word_t  mem_rdata,
	output logic                      mem_rdata_valid
);

	logic rd_pending_q;

	// lanes answer one cycle after the strobe, so the strobe is delayed to match
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_pending_q    <= 1'b0;
			mem_rdata_valid <= 1'b0;
		end else begin
			rd_pending_q    <= rd_pending;
			mem_rdata_valid <= rd_pending_q;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_pending_q)
			mem_rdata.bytes <= lane_rdata;
	end

endmodule

/* source/data_mem_ctrl.sv */
`timescale 1ns/1ps

module data_mem_ctrl (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic [mem_stage_pkg::MEM_CMD_W-1:0]  mem_cmd,
	input  logic [31:0]                          mem_addr,
	input  mem_stage_pkg::mem_word_t             mem_wdata,
	input  logic [3:0]                           mem_wmask,
	input  logic                                 read_done,
	output logic                                 mem_cmd_ready,
	output logic [3:0]                           lane_en,
	output logic [3:0]                           lane_we,
	output logic [mem_stage_pkg::DMEM_AW-1:0]    lane_addr,
	output logic [3:0][7:0]                      lane_wdata,
	output logic                                 rd_pending
);
	import mem_stage_pkg::*;

	logic read_busy;
	logic wr_accept;
	logic rd_accept;

	// commands are only taken while no read is outstanding
	assign mem_cmd_ready = !read_busy;
	assign wr_accept     = mem_cmd_ready && (mem_cmd == MEMORY_CMD_WRITE);
	assign rd_accept     = mem_cmd_ready && (mem_cmd == MEMORY_CMD_READ);

	assign lane_addr  = mem_addr[DMEM_AW+1:2];
	assign lane_wdata = mem_wdata.bytes;
	assign rd_pending = rd_accept;

	always_comb begin
		lane_en = 4'b0000;
		lane_we = 4'b0000;
		if (wr_accept) begin
			lane_en = mem_wmask;
			lane_we = mem_wmask;
		end else if (rd_accept) begin
			// a read always fetches the whole word
			lane_en = 4'b1111;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			read_busy <= 1'b0;
		end else if (rd_accept) begin
			read_busy <= 1'b1;
		end else if (read_done) begin
			read_busy <= 1'b0;
		end
	end

endmodule

/* source/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic [31:0]                          reg_pc,
	input  logic [31:0]                          rs2_data,
	input  logic [31:0]                          alu_out,
	input  logic [mem_stage_pkg::MEM_OP_W-1:0]   mem_wen,
	input  logic [mem_stage_pkg::WB_SEL_W-1:0]   wb_sel,
	input  logic                                 mem_cmd_ready,
	input  mem_stage_pkg::mem_word_t             mem_rdata,
	input  logic                                 mem_rdata_valid,
	output logic [31:0]                          read_data,
	output logic [31:0]                          out_reg_pc,
	output logic [31:0]                          out_alu_out,
	output logic [mem_stage_pkg::WB_SEL_W-1:0]   out_wb_sel,
	output logic                                 next_flg,
	output logic                                 is_stall,
	output logic [mem_stage_pkg::MEM_CMD_W-1:0]  mem_cmd,
	output logic [31:0]                          mem_addr,
	output mem_stage_pkg::mem_word_t             mem_wdata,
	output logic [3:0]                           mem_wmask
);
	import mem_stage_pkg::*;

	logic [STATE_W-1:0]  state;
	logic [31:0]         save_reg_pc;
	logic [31:0]         save_alu_out;
	logic [31:0]         save_rs2_data;
	logic [MEM_OP_W-1:0] save_mem_wen;
	logic [WB_SEL_W-1:0] save_wb_sel;
	logic [1:0]          offset;
	logic                is_store;
	mem_word_t           store_word;
	logic [3:0]          store_mask;
	logic [7:0]          load_byte;
	logic [15:0]         load_half;
	logic [31:0]         load_word;

	assign offset   = save_alu_out[1:0];
	assign is_store = (save_mem_wen == MEN_SB) || (save_mem_wen == MEN_SH) ||
		(save_mem_wen == MEN_SW);

	// a non-memory instruction passes straight through in the same cycle
	assign next_flg = ((state == ST_WAIT) && (mem_wen == MEN_X)) || (state == ST_END);
	assign is_stall = !next_flg;

	// place store data on the lanes picked by the low address bits
	always_comb begin
		store_word.word = '0;
		store_mask      = 4'b0000;
		case (save_mem_wen)
			MEN_SB: begin
				store_word.bytes[offset] = save_rs2_data[7:0];
				store_mask               = 4'b0001 << offset;
			end
			MEN_SH: begin
				store_word.halves[offset[1]] = save_rs2_data[15:0];
				store_mask                   = offset[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				store_word.word = save_rs2_data;
				store_mask      = 4'b1111;
			end
		endcase
	end

	assign load_byte = mem_rdata.bytes[offset];
	assign load_half = mem_rdata.halves[offset[1]];

	always_comb begin
		case (save_mem_wen)
			MEN_LB:  load_word = {{24{load_byte[7]}}, load_byte};
			MEN_LBU: load_word = {24'b0, load_byte};
			MEN_LH:  load_word = {{16{load_half[15]}}, load_half};
			MEN_LHU: load_word = {16'b0, load_half};
			default: load_word = mem_rdata.word;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= ST_WAIT;
			mem_cmd <= MEMORY_CMD_NOP;
		end else begin
			// commands last one cycle only
			mem_cmd <= MEMORY_CMD_NOP;
			case (state)
				ST_WAIT: begin
					if (mem_wen != MEN_X)
						state <= ST_WAIT_READY;
				end
				ST_WAIT_READY: begin
					if (mem_cmd_ready) begin
						mem_cmd <= is_store ? MEMORY_CMD_WRITE : MEMORY_CMD_READ;
						state   <= is_store ? ST_END : ST_WAIT_READ_VALID;
					end
				end
				ST_WAIT_READ_VALID: begin
					if (mem_rdata_valid)
						state <= ST_END;
				end
				default: state <= ST_WAIT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			ST_WAIT: begin
				if (mem_wen != MEN_X) begin
					save_reg_pc   <= reg_pc;
					save_alu_out  <= alu_out;
					save_rs2_data <= rs2_data;
					save_mem_wen  <= mem_wen;
					save_wb_sel   <= wb_sel;
				end else begin
					read_data   <= '1;
					out_reg_pc  <= reg_pc;
					out_alu_out <= alu_out;
					out_wb_sel  <= wb_sel;
				end
			end
			ST_WAIT_READY: begin
				if (mem_cmd_ready) begin
					mem_addr  <= save_alu_out;
					mem_wdata <= store_word;
					mem_wmask <= store_mask;
				end
			end
			ST_WAIT_READ_VALID: begin
				if (mem_rdata_valid)
					read_data <= load_word;
			end
			default: begin
				out_reg_pc  <= save_reg_pc;
				out_alu_out <= save_alu_out;
				out_wb_sel  <= save_wb_sel;
			end
		endcase
	end

endmodule

/* source/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [31:0]                         reg_pc,
	input  logic [31:0]                         rs2_data,
	input  logic [31:0]                         alu_out,
	input  logic [mem_stage_pkg::MEM_OP_W-1:0]  mem_wen,
	input  logic [mem_stage_pkg::WB_SEL_W-1:0]  wb_sel,
	output logic [31:0]                         read_data,
	output logic [31:0]                         out_reg_pc,
	output logic [31:0]                         out_alu_out,
	output logic [mem_stage_pkg::WB_SEL_W-1:0]  out_wb_sel,
	output logic                                next_flg,
	output logic                                is_stall
);
	import mem_stage_pkg::*;

	logic [MEM_CMD_W-1:0] mem_cmd;
	logic                 mem_cmd_ready;
	logic [31:0]          mem_addr;
	mem_word_t            mem_wdata;
	logic [3:0]           mem_wmask;
	mem_word_t            mem_rdata;
	logic                 mem_rdata_valid;
	logic [3:0]           lane_en;
	logic [3:0]           lane_we;
	logic [DMEM_AW-1:0]   lane_addr;
	logic [3:0][7:0]      lane_wdata;
	logic [3:0][7:0]      lane_rdata;
	logic                 rd_pending;

	memory_stage i_memory_stage (
		.clk             (clk),
		.rst_n           (rst_n),
		.reg_pc          (reg_pc),
		.rs2_data        (rs2_data),
		.alu_out         (alu_out),
		.mem_wen         (mem_wen),
		.wb_sel          (wb_sel),
		.mem_cmd_ready   (mem_cmd_ready),
		.mem_rdata       (mem_rdata),
		.mem_rdata_valid (mem_rdata_valid),
		.read_data       (read_data),
		.out_reg_pc      (out_reg_pc),
		.out_alu_out     (out_alu_out),
		.out_wb_sel      (out_wb_sel),
		.next_flg        (next_flg),
		.is_stall        (is_stall),
		.mem_cmd         (mem_cmd),
		.mem_addr        (mem_addr),
		.mem_wdata       (mem_wdata),
		.mem_wmask       (mem_wmask)
	);

	data_mem_ctrl i_data_mem_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.mem_cmd       (mem_cmd),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.mem_wmask     (mem_wmask),
		.read_done     (mem_rdata_valid),
		.mem_cmd_ready (mem_cmd_ready),
		.lane_en       (lane_en),
		.lane_we       (lane_we),
		.lane_addr     (lane_addr),
		.lane_wdata    (lane_wdata),
		.rd_pending    (rd_pending)
	);

	for (genvar i = 0; i < 4; i++) begin : g_lane
		byte_lane_ram i_byte_lane_ram (
			.clk   (clk),
			.en    (lane_en[i]),
			.we    (lane_we[i]),
			.addr  (lane_addr),
			.wdata (lane_wdata[i]),
			.rdata (lane_rdata[i])
		);
	end

	read_return i_read_return (
		.clk             (clk),
		.rst_n           (rst_n),
		.lane_rdata      (lane_rdata),
		.rd_pending      (rd_pending),
		.mem_rdata       (mem_rdata),
		.mem_rdata_valid (mem_rdata_valid)
	);

endmodule

/* tests/tb_mem_tasks.svh */
`ifndef TB_MEM_TASKS_SVH
`define TB_MEM_TASKS_SVH

localparam int TIMEOUT_CYCLES = 40;

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		$display("[ERROR] %s: got %08h, expected %08h", name, got, exp);
		errors++;
	end
endtask

task automatic check_sel(input string name, input logic [WB_SEL_W-1:0] got,
	input logic [WB_SEL_W-1:0] exp);
	if (got !== exp) begin
		$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		errors++;
	end
endtask

// drives one instruction at the falling edge and waits for next_flg
// with scramble set, the upstream inputs change once the stage has saved them
task automatic run_op(input logic [MEM_OP_W-1:0] op, input logic [31:0] addr,
	input logic [31:0] data, input bit scramble);
	logic [31:0]         pc;
	logic [WB_SEL_W-1:0] sel;
	int                  stall;
	int                  exp_stall;
	pc        = $random(seed);
	sel       = WB_SEL_W'($random(seed));
	stall     = 0;
	exp_stall = 5;
	if (op == MEN_X)
		exp_stall = 0;
	else if (op == MEN_SB || op == MEN_SH || op == MEN_SW)
		exp_stall = 2;
	mem_wen  = op;
	reg_pc   = pc;
	alu_out  = addr;
	rs2_data = data;
	wb_sel   = sel;
	#1;
	while (next_flg !== 1'b1) begin
		stall++;
		if (is_stall !== 1'b1) begin
			$display("is_stall is low while op %0h waits for next_flg", op);
			errors++;
		end
		if (stall > TIMEOUT_CYCLES)
			timed_out = 1'b1;
		@(negedge clk);
		if (scramble) begin
			reg_pc   = ~pc;
			alu_out  = ~addr;
			rs2_data = ~data;
			wb_sel   = ~sel;
		end
		#1;
	end
	if (is_stall !== 1'b0) begin
		$display("is_stall is high together with next_flg for op %0h", op);
		errors++;
	end
	if (stall != exp_stall) begin
		$display("op %0h stalled for %0d cycles instead of %0d", op, stall, exp_stall);
		errors++;
	end
	// the results are registered on the edge that ends the next_flg cycle
	@(negedge clk);
	mem_wen = MEN_X;
	check_word("out_reg_pc", out_reg_pc, pc);
	check_word("out_alu_out", out_alu_out, addr);
	check_sel("out_wb_sel", out_wb_sel, sel);
endtask

task automatic store_data(input logic [MEM_OP_W-1:0] op, input logic [31:0] addr,
	input logic [31:0] data, input bit scramble);
	mem_word_t w;
	run_op(op, addr, data, scramble);
	w = model_mem[addr[DMEM_AW+1:2]];
	case (op)
		MEN_SB:  w.bytes[addr[1:0]] = data[7:0];
		MEN_SH:  w.halves[addr[1]] = data[15:0];
		default: w.word = data;
	endcase
	model_mem[addr[DMEM_AW+1:2]] = w;
endtask

task automatic load_check(input logic [MEM_OP_W-1:0] op, input logic [31:0] addr,
	input bit scramble);
	mem_word_t   w;
	logic [7:0]  b;
	logic [15:0] h;
	logic [31:0] exp;
	run_op(op, addr, $random(seed), scramble);
	w = model_mem[addr[DMEM_AW+1:2]];
	b = w.bytes[addr[1:0]];
	h = w.halves[addr[1]];
	case (op)
		MEN_LB:  exp = {{24{b[7]}}, b};
		MEN_LBU: exp = {24'd0, b};
		MEN_LH:  exp = {{16{h[15]}}, h};
		MEN_LHU: exp = {16'd0, h};
		default: exp = w.word;
	endcase
	check_word("read_data", read_data, exp);
endtask

`endif

/* tests/tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;
	import mem_stage_pkg::*;

	logic                clk;
	logic                rst_n;
	logic [31:0]         reg_pc;
	logic [31:0]         rs2_data;
	logic [31:0]         alu_out;
	logic [MEM_OP_W-1:0] mem_wen;
	logic [WB_SEL_W-1:0] wb_sel;
	logic [31:0]         read_data;
	logic [31:0]         out_reg_pc;
	logic [31:0]         out_alu_out;
	logic [WB_SEL_W-1:0] out_wb_sel;
	logic                next_flg;
	logic                is_stall;
	logic                timed_out;
	integer              seed;
	int                  errors;
	int                  test_count;
	int                  failed_tests;
	mem_word_t           model_mem [DMEM_WORDS];

	mem_subsystem i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.reg_pc      (reg_pc),
		.rs2_data    (rs2_data),
		.alu_out     (alu_out),
		.mem_wen     (mem_wen),
		.wb_sel      (wb_sel),
		.read_data   (read_data),
		.out_reg_pc  (out_reg_pc),
		.out_alu_out (out_alu_out),
		.out_wb_sel  (out_wb_sel),
		.next_flg    (next_flg),
		.is_stall    (is_stall)
	);

	always #4 clk = ~clk;

	// a wait that runs past its limit ends the run here
	initial begin
		@(posedge timed_out);
		$display("timeout while waiting for next_flg");
		$display("Some tests failed");
		$finish;
	end

	`include "tb_mem_tasks.svh"

	task automatic finish_test(input string name, input int errors_before);
		test_count++;
		if (errors == errors_before) begin
			$display("%s: ok", name);
		end else begin
			failed_tests++;
			$display("%s: %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic pass_through_test();
		int e;
		e = errors;
		for (int i = 0; i < 3; i++)
			run_op(MEN_X, $random(seed), $random(seed), 1'b0);
		check_word("read_data", read_data, 32'hffff_ffff);
		finish_test("pass-through", e);
	endtask

	task automatic word_round_trip();
		logic [31:0] addrs [4];
		int          e;
		e = errors;
		for (int i = 0; i < 4; i++) begin
			addrs[i] = {22'd0, 8'($random(seed)), 2'b00};
			store_data(MEN_SW, addrs[i], $random(seed), 1'b1);
		end
		for (int i = 0; i < 4; i++)
			load_check(MEN_LW, addrs[i], 1'b1);
		finish_test("word store and load", e);
	endtask

	task automatic byte_lane_masks();
		int e;
		e = errors;
		store_data(MEN_SW, 32'h100, $random(seed), 1'b0);
		for (int k = 0; k < 4; k++) begin
			store_data(MEN_SB, 32'h100 + 32'(k), $random(seed), 1'b0);
			load_check(MEN_LW, 32'h100, 1'b0);
		end
		finish_test("byte lane masks", e);
	endtask

	task automatic half_sign_rules();
		logic neg;
		int   e;
		e = errors;
		for (int r = 0; r < 2; r++) begin
			neg = (r == 0);
			store_data(MEN_SW, 32'h200, $random(seed), 1'b0);
			store_data(MEN_SH, 32'h200, {16'($random(seed)), neg, 15'($random(seed))}, 1'b0);
			store_data(MEN_SH, 32'h202, {16'($random(seed)), !neg, 15'($random(seed))}, 1'b0);
			load_check(MEN_LH, 32'h200, 1'b0);
			load_check(MEN_LHU, 32'h200, 1'b0);
			load_check(MEN_LH, 32'h202, 1'b0);
			load_check(MEN_LHU, 32'h202, 1'b0);
		end
		finish_test("half sign rules", e);
	endtask

	task automatic byte_sign_rules();
		mem_word_t w;
		int        e;
		e = errors;
		for (int r = 0; r < 2; r++) begin
			// bit 7 alternates across the lanes and flips between rounds
			for (int k = 0; k < 4; k++)
				w.bytes[k] = {((k % 2) == r), 7'($random(seed))};
			store_data(MEN_SW, 32'h300, w.word, 1'b0);
			for (int k = 0; k < 4; k++) begin
				load_check(MEN_LB, 32'h300 + 32'(k), 1'b0);
				load_check(MEN_LBU, 32'h300 + 32'(k), 1'b0);
			end
		end
		finish_test("byte sign rules", e);
	endtask

	task automatic back_to_back();
		logic [31:0] addr;
		int          e;
		e = errors;
		for (int i = 0; i < 6; i++) begin
			addr = {22'd0, 8'($random(seed)), 2'b00};
			store_data(MEN_SW, addr, $random(seed), 1'b0);
			load_check(MEN_LW, addr, 1'b0);
			store_data(MEN_SB, addr + 32'd3, $random(seed), 1'b0);
			load_check(MEN_LHU, addr + 32'd2, 1'b0);
		end
		run_op(MEN_X, $random(seed), $random(seed), 1'b0);
		check_word("read_data", read_data, 32'hffff_ffff);
		finish_test("back-to-back", e);
	endtask

	initial begin
		seed         = 32'h947da7fe;
		errors       = 0;
		test_count   = 0;
		failed_tests = 0;
		timed_out    = 1'b0;
		clk          = 1'b0;
		rst_n        = 1'b0;
		reg_pc       = '0;
		rs2_data     = '0;
		alu_out      = '0;
		mem_wen      = MEN_X;
		wb_sel       = '0;
		repeat (16) @(negedge clk);
		if (is_stall !== 1'b0) begin
			$display("is_stall is high after reset with no memory access");
			errors++;
		end
		rst_n = 1'b1;
		pass_through_test();
		word_round_trip();
		byte_lane_masks();
		half_sign_rules();
		byte_sign_rules();
		back_to_back();
		$display("tests run: %0d, tests failed: %0d, errors: %0d",
			test_count, failed_tests, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* mem_subsystem.f */
+incdir+tests
source/mem_stage_pkg.sv
source/byte_lane_ram.sv
source/read_return.sv
source/data_mem_ctrl.sv
source/memory_stage.sv
source/mem_subsystem.sv
tests/tb_mem_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_mem_subsystem -f mem_subsystem.f \
	&& ./obj_dir/Vtb_mem_subsystem > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log 2>/dev/null && echo "simulation passed" && exit 0 \
	|| { echo "simulation failed"; exit 1; }
